// File: compile.f
soc_pkg.sv
core_ahb_bridge.sv
ahb_decoder.sv
ahb_sram.sv
ahb_apb_bridge.sv
apb_pwm.sv
soc_top.sv
soc_assertions.sv
tb_soc_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SoC bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_soc_top -o tb_soc_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

// File: tb_soc_top.sv
`timescale 1ns/1ns

module tb_soc_top;
  import soc_pkg::*;

  localparam int TIMEOUT = 50;

  logic                clk;
  logic                arst_n;
  logic                req;
  logic                we;
  logic [STRB_W-1:0]   be;
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic                gnt;
  logic                rvalid;
  logic [DATA_W-1:0]   rdata;
  logic                err;
  logic [PWM_CH-1:0]   pwm;
  integer              seed;
  int                  errors;
  int                  tests_ok;
  int                  tests_bad;
  int                  err_mark;
  logic [DATA_W-1:0]   model [2**SRAM_AW];
  logic [STRB_W-1:0]   be_list [7] = '{4'b1111, 4'b0001, 4'b0010, 4'b0100,
                                       4'b1000, 4'b0011, 4'b1100};

  always #4 clk = ~clk;

  soc_top DUT (
    .clk_cpu_i (clk),   .arst_n_i (arst_n),
    .req_i     (req),   .we_i     (we),     .be_i    (be),
    .addr_i    (addr),  .wdata_i  (wdata),
    .gnt_o     (gnt),   .rvalid_o (rvalid), .rdata_o (rdata),
    .err_o     (err),   .pwm_o    (pwm)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_lat(input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t: rvalid_o latency got %0d expected %0d", $time, got, exp);
      errors++;
    end
  endtask

  task automatic wait_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (gnt !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (gnt !== 1'b1) begin
      $display("timeout at %0t: request was never granted", $time);
      errors++;
    end
  endtask

  task automatic wait_response(output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (rvalid !== 1'b1 && lat < TIMEOUT);
    if (rvalid !== 1'b1) begin
      $display("timeout at %0t: no response after the grant", $time);
      errors++;
    end
  endtask

  // Single transfer that waits for its response
  task automatic access(input logic w, input logic [3:0] b, input logic [31:0] a,
                        input logic [31:0] d, output logic [31:0] rd, output logic e,
                        output int lat);
    @(posedge clk);
    req   <= 1'b1;
    we    <= w;
    be    <= b;
    addr  <= a;
    wdata <= d;
    wait_grant();
    @(posedge clk);
    req <= 1'b0;
    wait_response(lat);
    rd = rdata;
    e  = err;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] b);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) begin
        res[8*i +: 8] = d[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Write followed by a read of the same word in the very next address phase
  task automatic write_then_read(input logic [7:0] widx, input logic [3:0] b,
                                 input logic [31:0] d);
    int lat;
    @(posedge clk);
    req   <= 1'b1;
    we    <= 1'b1;
    be    <= b;
    addr  <= {22'h0, widx, 2'b00};
    wdata <= d;
    wait_grant();
    @(posedge clk);
    we <= 1'b0;
    be <= 4'hf;
    model[widx] = merge_bytes(model[widx], d, b);
    wait_grant();
    check_val("rvalid_o", {31'h0, rvalid}, 32'h1);
    @(posedge clk);
    req <= 1'b0;
    wait_response(lat);
    check_lat(lat, 1);
    check_val("rdata_o", rdata, model[widx]);
  endtask

  task automatic end_test(input string name);
    int total;
    total = errors + DUT.u_soc_assertions.fail_cnt;
    if (total == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAILED", name);
    end
    err_mark = total;
  endtask

  initial begin
    logic [31:0] rd;
    logic        e;
    int          lat;
    logic [7:0]  widx;
    logic [31:0] d;
    logic [7:0]  ofs [6] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14};
    int          duty [4] = '{3, 7, 5, 12};
    int          cnt [4];
    int          exp;

    clk      = 1'b0;
    arst_n   = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    be       = '0;
    addr     = '0;
    wdata    = '0;
    seed     = 32'haa6f1251;
    errors   = 0;
    tests_ok = 0;
    tests_bad = 0;
    err_mark = 0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    repeat (3) begin
      @(negedge clk);
      check_val("gnt_o", {31'h0, gnt}, 32'h0);
      check_val("rvalid_o", {31'h0, rvalid}, 32'h0);
      check_val("err_o", {31'h0, err}, 32'h0);
      check_val("pwm_o", {28'h0, pwm}, 32'h0);
    end
    end_test("reset");

    for (int i = 0; i < 8; i++) begin
      widx = 8'($random(seed));
      write_then_read(widx, 4'hf, $random(seed));
      write_then_read(widx, be_list[int'({$random(seed)} % 7)], $random(seed));
      access(1'b0, 4'hf, {22'h0, widx, 2'b00}, 32'h0, rd, e, lat);
      check_lat(lat, 1);
      check_val("rdata_o", rd, model[widx]);
    end
    end_test("sram");

    for (int i = 0; i < 6; i++) begin
      d = $random(seed);
      access(1'b1, 4'hf, APB_BASE | {24'h0, ofs[i]}, d, rd, e, lat);
      check_lat(lat, 2);
      access(1'b0, 4'hf, APB_BASE | {24'h0, ofs[i]}, 32'h0, rd, e, lat);
      check_lat(lat, 2);
      check_val("rdata_o", rd, (i == 0) ? (d & 32'hF) : (d & 32'hFFFF));
    end
    access(1'b0, 4'hf, APB_BASE | 32'h18, 32'h0, rd, e, lat);
    check_val("rdata_o", rd, 32'h0);
    access(1'b0, 4'hf, APB_BASE | 32'h40, 32'h0, rd, e, lat);
    check_val("rdata_o", rd, 32'h0);
    end_test("pwm_registers");

    access(1'b1, 4'hf, 32'h3000_0010, 32'h1234_5678, rd, e, lat);
    check_lat(lat, 2);
    check_val("err_o", {31'h0, e}, 32'h1);
    access(1'b0, 4'hf, 32'hF000_0000, 32'h0, rd, e, lat);
    check_lat(lat, 2);
    check_val("err_o", {31'h0, e}, 32'h1);
    access(1'b0, 4'hf, {22'h0, widx, 2'b00}, 32'h0, rd, e, lat);
    check_lat(lat, 1);
    check_val("err_o", {31'h0, e}, 32'h0);
    check_val("rdata_o", rd, model[widx]);
    end_test("unmapped");

    // Period 10 with channel 2 left disabled
    access(1'b1, 4'hf, APB_BASE | 32'h04, 32'd10, rd, e, lat);
    for (int k = 0; k < 4; k++) begin
      access(1'b1, 4'hf, APB_BASE | 32'(8 + 4 * k), 32'(duty[k]), rd, e, lat);
    end
    access(1'b1, 4'hf, APB_BASE, 32'hB, rd, e, lat);
    repeat (25) @(negedge clk);
    cnt = '{0, 0, 0, 0};
    repeat (10) begin
      @(negedge clk);
      for (int k = 0; k < 4; k++) begin
        cnt[k] += int'(pwm[k]);
      end
    end
    for (int k = 0; k < 4; k++) begin
      exp = (k == 2) ? 0 : ((duty[k] < 10) ? duty[k] : 10);
      check_val($sformatf("pwm_o[%0d] high cycles", k), 32'(cnt[k]), 32'(exp));
    end
    end_test("pwm_outputs");

    $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_ok, tests_bad, errors, DUT.u_soc_assertions.fail_cnt);
    if (errors == 0 && tests_bad == 0 && DUT.u_soc_assertions.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: soc_assertions.sv
`timescale 1ns/1ns

module soc_assertions (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [soc_pkg::STRB_W-1:0]   be_i,
  input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  input  logic                         gnt_o,
  input  logic                         rvalid_o,
  input  logic [soc_pkg::DATA_W-1:0]   rdata_o,
  input  logic                         err_o,
  input  logic [soc_pkg::PWM_CH-1:0]   pwm_o,
  input  soc_pkg::apb_state_e          apb_state_i
);
  import soc_pkg::*;

  logic                             acc;
  logic                             is_sram;
  logic                             is_apb;
  logic                             is_err;
  logic [DATA_W-1:0]                exp_val;
  logic [DATA_W-1:0]                shadow_mem [2**SRAM_AW];
  logic [PWM_CH-1:0]                sh_ctrl;
  logic [PWM_CNT_W-1:0]             sh_period;
  logic [PWM_CH-1:0][PWM_CNT_W-1:0] sh_duty;
  // In-flight transfers with the oldest in slot 0
  logic [1:0]                       q_cnt;
  logic                             q_err [2];
  logic                             q_rd [2];
  logic [DATA_W-1:0]                q_exp [2];
  int                               fail_cnt = 0;

  assign acc     = req_i & gnt_o;
  assign is_sram = (addr_i & REGION_MASK) == (SRAM_BASE & REGION_MASK);
  assign is_apb  = (addr_i & REGION_MASK) == (APB_BASE & REGION_MASK);
  assign is_err  = ~is_sram & ~is_apb;

  always_comb begin
    exp_val = '0;
    if (is_sram) begin
      exp_val = shadow_mem[addr_i[SRAM_AW+1:2]];
    end else if (is_apb) begin
      if (addr_i[7:0] == PWM_CTRL_OFS) begin
        exp_val[PWM_CH-1:0] = sh_ctrl;
      end
      if (addr_i[7:0] == PWM_PERIOD_OFS) begin
        exp_val[PWM_CNT_W-1:0] = sh_period;
      end
      for (int k = 0; k < PWM_CH; k++) begin
        if (addr_i[7:0] == 8'(PWM_DUTY_OFS + 4 * k)) begin
          exp_val[PWM_CNT_W-1:0] = sh_duty[k];
        end
      end
    end
  end

  // ----------------------------
  // Shadow models
  // ----------------------------
  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sh_ctrl   <= '0;
      sh_period <= '0;
      sh_duty   <= '0;
    end else if (acc && we_i && is_apb) begin
      if (addr_i[7:0] == PWM_CTRL_OFS) begin
        sh_ctrl <= wdata_i[PWM_CH-1:0];
      end
      if (addr_i[7:0] == PWM_PERIOD_OFS) begin
        sh_period <= wdata_i[PWM_CNT_W-1:0];
      end
      for (int k = 0; k < PWM_CH; k++) begin
        if (addr_i[7:0] == 8'(PWM_DUTY_OFS + 4 * k)) begin
          sh_duty[k] <= wdata_i[PWM_CNT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_cpu_i) begin
    if (acc && we_i && is_sram) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (be_i[b]) begin
          shadow_mem[addr_i[SRAM_AW+1:2]][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      q_cnt <= '0;
    end else begin
      case ({acc, rvalid_o})
        2'b10: begin
          q_err[q_cnt[0]] <= is_err;
          q_rd[q_cnt[0]]  <= ~we_i;
          q_exp[q_cnt[0]] <= exp_val;
          q_cnt           <= q_cnt + 2'd1;
        end
        2'b01: begin
          q_err[0] <= q_err[1];
          q_rd[0]  <= q_rd[1];
          q_exp[0] <= q_exp[1];
          q_cnt    <= q_cnt - 2'd1;
        end
        2'b11: begin
          if (q_cnt == 2'd1) begin
            q_err[0] <= is_err;
            q_rd[0]  <= ~we_i;
            q_exp[0] <= exp_val;
          end else begin
            q_err[0] <= q_err[1];
            q_rd[0]  <= q_rd[1];
            q_exp[0] <= q_exp[1];
            q_err[1] <= is_err;
            q_rd[1]  <= ~we_i;
            q_exp[1] <= exp_val;
          end
        end
        default: ;
      endcase
    end
  end

  // ----------------------------
  // Properties
  // ----------------------------
  a_reset_idle: assert property (@(posedge clk_cpu_i)
    $rose(arst_n_i) |-> !gnt_o && !rvalid_o && !err_o && pwm_o == '0 && apb_state_i == APB_IDLE)
    else begin
      $error("outputs or APB FSM not idle after reset");
      fail_cnt++;
    end

  a_no_orphan: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    rvalid_o |-> q_cnt != 2'd0)
    else begin
      $error("rvalid_o without an accepted request");
      fail_cnt++;
    end

  a_depth: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    acc |-> (q_cnt < 2'd2) || rvalid_o)
    else begin
      $error("more than two transfers in flight");
      fail_cnt++;
    end

  a_err_flag: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    rvalid_o |-> err_o == q_err[0])
    else begin
      $error("err_o does not match the region of the transfer");
      fail_cnt++;
    end

  a_rdata: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    rvalid_o && q_rd[0] && !q_err[0] |-> rdata_o == q_exp[0])
    else begin
      $error("rdata_o differs from the shadow value");
      fail_cnt++;
    end

  a_sram_lat: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    acc && is_sram |=> rvalid_o)
    else begin
      $error("SRAM response not one cycle after grant");
      fail_cnt++;
    end

  a_slow_lat: assert property (@(posedge clk_cpu_i) disable iff (!arst_n_i)
    acc && !is_sram |=> !rvalid_o ##1 rvalid_o)
    else begin
      $error("APB or error response not two cycles after grant");
      fail_cnt++;
    end

endmodule

bind soc_top soc_assertions u_soc_assertions (
  .clk_cpu_i   (clk_cpu_i),
  .arst_n_i    (arst_n_i),
  .req_i       (req_i),
  .we_i        (we_i),
  .be_i        (be_i),
  .addr_i      (addr_i),
  .wdata_i     (wdata_i),
  .gnt_o       (gnt_o),
  .rvalid_o    (rvalid_o),
  .rdata_o     (rdata_o),
  .err_o       (err_o),
  .pwm_o       (pwm_o),
  .apb_state_i (u_ahb_apb_bridge.state_q)
);

// File: soc_top.sv
`timescale 1ns/1ns

module soc_top (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [soc_pkg::STRB_W-1:0]   be_i,
  input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic                         err_o,
  output logic [soc_pkg::PWM_CH-1:0]   pwm_o
);
  import soc_pkg::*;

  // Master side
  htrans_e           htrans;
  logic [ADDR_W-1:0] haddr;
  logic              hwrite;
  logic [2:0]        hsize;
  logic [DATA_W-1:0] hwdata;
  logic [DATA_W-1:0] hrdata;
  logic              hready;
  hresp_e            hresp;
  logic              hready_in;

  // Slaves
  logic              sram_hsel;
  logic              sram_hreadyout;
  hresp_e            sram_hresp;
  logic [DATA_W-1:0] sram_hrdata;
  logic              apb_hsel;
  logic              apb_hreadyout;
  hresp_e            apb_hresp;
  logic [DATA_W-1:0] apb_hrdata;

  // APB
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [7:0]        paddr;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;

  core_ahb_bridge u_core_ahb_bridge (
    .clk_cpu_i (clk_cpu_i), .arst_n_i (arst_n_i),
    .req_i     (req_i),     .we_i     (we_i),     .be_i    (be_i),
    .addr_i    (addr_i),    .wdata_i  (wdata_i),
    .gnt_o     (gnt_o),     .rvalid_o (rvalid_o), .rdata_o (rdata_o),
    .err_o     (err_o),
    .htrans_o  (htrans),    .haddr_o  (haddr),    .hwrite_o (hwrite),
    .hsize_o   (hsize),     .hwdata_o (hwdata),
    .hrdata_i  (hrdata),    .hready_i (hready),   .hresp_i  (hresp)
  );

  ahb_decoder u_ahb_decoder (
    .clk_cpu_i        (clk_cpu_i),      .arst_n_i        (arst_n_i),
    .htrans_i         (htrans),         .haddr_i         (haddr),
    .sram_hsel_o      (sram_hsel),      .apb_hsel_o      (apb_hsel),
    .hready_in_o      (hready_in),
    .sram_hrdata_i    (sram_hrdata),    .sram_hreadyout_i (sram_hreadyout),
    .sram_hresp_i     (sram_hresp),
    .apb_hrdata_i     (apb_hrdata),     .apb_hreadyout_i (apb_hreadyout),
    .apb_hresp_i      (apb_hresp),
    .hrdata_o         (hrdata),         .hready_o        (hready),
    .hresp_o          (hresp)
  );

  ahb_sram u_ahb_sram (
    .clk_cpu_i   (clk_cpu_i),      .arst_n_i (arst_n_i),
    .hsel_i      (sram_hsel),      .hready_i (hready_in),
    .htrans_i    (htrans),         .hwrite_i (hwrite),
    .hsize_i     (hsize),          .haddr_i  (haddr),
    .hwdata_i    (hwdata),
    .hreadyout_o (sram_hreadyout), .hresp_o  (sram_hresp),
    .hrdata_o    (sram_hrdata)
  );

  ahb_apb_bridge u_ahb_apb_bridge (
    .clk_cpu_i   (clk_cpu_i),     .arst_n_i  (arst_n_i),
    .hsel_i      (apb_hsel),      .hready_i  (hready_in),
    .htrans_i    (htrans),        .hwrite_i  (hwrite),
    .haddr_i     (haddr),         .hwdata_i  (hwdata),
    .hreadyout_o (apb_hreadyout), .hresp_o   (apb_hresp),
    .hrdata_o    (apb_hrdata),
    .psel_o      (psel),          .penable_o (penable),
    .pwrite_o    (pwrite),        .paddr_o   (paddr),
    .pwdata_o    (pwdata),        .prdata_i  (prdata)
  );

  apb_pwm u_apb_pwm (
    .clk_cpu_i (clk_cpu_i), .arst_n_i  (arst_n_i),
    .psel_i    (psel),      .penable_i (penable),
    .pwrite_i  (pwrite),    .paddr_i   (paddr),
    .pwdata_i  (pwdata),    .prdata_o  (prdata),
    .pwm_o     (pwm_o)
  );

endmodule

// File: apb_pwm.sv
`timescale 1ns/1ns

module apb_pwm (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [7:0]                   paddr_i,
  input  logic [soc_pkg::DATA_W-1:0]   pwdata_i,
  output logic [soc_pkg::DATA_W-1:0]   prdata_o,
  output logic [soc_pkg::PWM_CH-1:0]   pwm_o
);
  import soc_pkg::*;

  logic                                wr_en;
  logic [PWM_CH-1:0]                   ctrl_q;
  logic [PWM_CNT_W-1:0]                period_q;
  logic [PWM_CH-1:0][PWM_CNT_W-1:0]    duty_q;
  logic [PWM_CNT_W-1:0]                cnt_q;
  logic [PWM_CNT_W-1:0]                cnt_nxt;

  assign wr_en = psel_i & penable_i & pwrite_i;

  // ----------------------------
  // Register file
  // ----------------------------
  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_q   <= '0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_en) begin
      if (paddr_i == PWM_CTRL_OFS) begin
        ctrl_q <= pwdata_i[PWM_CH-1:0];
      end
      if (paddr_i == PWM_PERIOD_OFS) begin
        period_q <= pwdata_i[PWM_CNT_W-1:0];
      end
      for (int k = 0; k < PWM_CH; k++) begin
        if (paddr_i == 8'(PWM_DUTY_OFS + 4 * k)) begin
          duty_q[k] <= pwdata_i[PWM_CNT_W-1:0];
        end
      end
    end
  end

  // Unused offsets read zero
  always_comb begin
    prdata_o = '0;
    if (paddr_i == PWM_CTRL_OFS) begin
      prdata_o[PWM_CH-1:0] = ctrl_q;
    end
    if (paddr_i == PWM_PERIOD_OFS) begin
      prdata_o[PWM_CNT_W-1:0] = period_q;
    end
    for (int k = 0; k < PWM_CH; k++) begin
      if (paddr_i == 8'(PWM_DUTY_OFS + 4 * k)) begin
        prdata_o[PWM_CNT_W-1:0] = duty_q[k];
      end
    end
  end

  // Shared period counter, 0 .. period-1
  assign cnt_nxt = cnt_q + 1'b1;

  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      pwm_o <= '0;
    end else begin
      cnt_q <= (cnt_nxt >= period_q) ? '0 : cnt_nxt;
      for (int k = 0; k < PWM_CH; k++) begin
        pwm_o[k] <= ctrl_q[k] & (cnt_q < duty_q[k]);
      end
    end
  end

endmodule

// File: ahb_apb_bridge.sv
`timescale 1ns/1ns

module ahb_apb_bridge (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  // AHB-lite slave side
  input  logic                         hsel_i,
  input  logic                         hready_i,
  input  soc_pkg::htrans_e             htrans_i,
  input  logic                         hwrite_i,
  input  logic [soc_pkg::ADDR_W-1:0]   haddr_i,
  input  logic [soc_pkg::DATA_W-1:0]   hwdata_i,
  output logic                         hreadyout_o,
  output soc_pkg::hresp_e              hresp_o,
  output logic [soc_pkg::DATA_W-1:0]   hrdata_o,
  // APB master side
  output logic                         psel_o,
  output logic                         penable_o,
  output logic                         pwrite_o,
  output logic [7:0]                   paddr_o,
  output logic [soc_pkg::DATA_W-1:0]   pwdata_o,
  input  logic [soc_pkg::DATA_W-1:0]   prdata_i
);
  import soc_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       acc;
  logic [7:0] paddr_q;
  logic       pwrite_q;

  assign acc = hsel_i & hready_i & (htrans_i inside {NONSEQ, SEQ});

  // ----------------------------
  // Setup / access FSM
  // ----------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   state_d = acc ? APB_SETUP : APB_IDLE;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: state_d = acc ? APB_SETUP : APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= APB_IDLE;
      paddr_q  <= '0;
      pwrite_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Capture the address phase
      if (acc) begin
        paddr_q  <= haddr_i[7:0];
        pwrite_q <= hwrite_i;
      end
    end
  end

  assign psel_o    = (state_q == APB_SETUP) || (state_q == APB_ACCESS);
  assign penable_o = (state_q == APB_ACCESS);
  assign pwrite_o  = pwrite_q;
  assign paddr_o   = paddr_q;
  // Master holds hwdata through the stretched data phase
  assign pwdata_o  = hwdata_i;

  assign hreadyout_o = (state_q != APB_SETUP);
  assign hresp_o     = OKAY;
  assign hrdata_o    = prdata_i;

endmodule

// File: ahb_sram.sv
`timescale 1ns/1ns

module ahb_sram (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  input  logic                         hsel_i,
  input  logic                         hready_i,
  input  soc_pkg::htrans_e             htrans_i,
  input  logic                         hwrite_i,
  input  logic [2:0]                   hsize_i,
  input  logic [soc_pkg::ADDR_W-1:0]   haddr_i,
  input  logic [soc_pkg::DATA_W-1:0]   hwdata_i,
  output logic                         hreadyout_o,
  output soc_pkg::hresp_e              hresp_o,
  output logic [soc_pkg::DATA_W-1:0]   hrdata_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0]  mem [2**SRAM_AW];
  logic               acc;
  logic [SRAM_AW-1:0] acc_addr;
  logic [STRB_W-1:0]  acc_be;
  logic [DATA_W-1:0]  rd_word;
  // One-entry write buffer, data arrives in the data phase
  logic               buf_pend_q;
  logic [SRAM_AW-1:0] buf_addr_q;
  logic [STRB_W-1:0]  buf_be_q;
  logic [DATA_W-1:0]  rdata_q;

  assign acc      = hsel_i & hready_i & (htrans_i inside {NONSEQ, SEQ});
  assign acc_addr = haddr_i[SRAM_AW+1:2];

  always_comb begin
    case (hsize_i)
      3'b000:  acc_be = STRB_W'(1) << haddr_i[1:0];
      3'b001:  acc_be = haddr_i[1] ? 4'b1100 : 4'b0011;
      default: acc_be = '1;
    endcase
  end

  // Read path sees the bytes still sitting in the buffer
  always_comb begin
    rd_word = mem[acc_addr];
    for (int b = 0; b < STRB_W; b++) begin
      if (buf_pend_q && buf_be_q[b] && (buf_addr_q == acc_addr)) begin
        rd_word[8*b +: 8] = hwdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_pend_q <= 1'b0;
    end else if (hready_i) begin
      buf_pend_q <= acc & hwrite_i;
    end
  end

  always_ff @(posedge clk_cpu_i) begin
    if (acc && hwrite_i) begin
      buf_addr_q <= acc_addr;
      buf_be_q   <= acc_be;
    end
    if (buf_pend_q && hready_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (buf_be_q[b]) begin
          mem[buf_addr_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
    if (acc && !hwrite_i) begin
      rdata_q <= rd_word;
    end
  end

  assign hrdata_o    = rdata_q;
  assign hreadyout_o = 1'b1;
  assign hresp_o     = OKAY;

endmodule

// File: ahb_decoder.sv
`timescale 1ns/1ns

module ahb_decoder (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  input  soc_pkg::htrans_e             htrans_i,
  input  logic [soc_pkg::ADDR_W-1:0]   haddr_i,
  // Slave selects
  output logic                         sram_hsel_o,
  output logic                         apb_hsel_o,
  output logic                         hready_in_o,
  // SRAM response
  input  logic [soc_pkg::DATA_W-1:0]   sram_hrdata_i,
  input  logic                         sram_hreadyout_i,
  input  soc_pkg::hresp_e              sram_hresp_i,
  // APB bridge response
  input  logic [soc_pkg::DATA_W-1:0]   apb_hrdata_i,
  input  logic                         apb_hreadyout_i,
  input  soc_pkg::hresp_e              apb_hresp_i,
  // Muxed response to the master
  output logic [soc_pkg::DATA_W-1:0]   hrdata_o,
  output logic                         hready_o,
  output soc_pkg::hresp_e              hresp_o
);
  import soc_pkg::*;

  logic hit_sram;
  logic hit_apb;
  logic active;
  logic dp_sram_q;
  logic dp_apb_q;
  logic dp_def_q;
  logic def_wait_q;

  assign hit_sram    = (haddr_i & REGION_MASK) == (SRAM_BASE & REGION_MASK);
  assign hit_apb     = (haddr_i & REGION_MASK) == (APB_BASE & REGION_MASK);
  assign active      = htrans_i inside {NONSEQ, SEQ};
  assign sram_hsel_o = hit_sram;
  assign apb_hsel_o  = hit_apb;
  assign hready_in_o = hready_o;

  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_sram_q  <= 1'b0;
      dp_apb_q   <= 1'b0;
      dp_def_q   <= 1'b0;
      def_wait_q <= 1'b0;
    end else begin
      if (hready_o) begin
        dp_sram_q <= active & hit_sram;
        dp_apb_q  <= active & hit_apb;
        dp_def_q  <= active & ~hit_sram & ~hit_apb;
      end
      // Error slave, first response cycle is a wait state
      def_wait_q <= hready_o & active & ~hit_sram & ~hit_apb;
    end
  end

  always_comb begin
    hrdata_o = '0;
    hready_o = 1'b1;
    hresp_o  = OKAY;
    if (dp_sram_q) begin
      hrdata_o = sram_hrdata_i;
      hready_o = sram_hreadyout_i;
      hresp_o  = sram_hresp_i;
    end else if (dp_apb_q) begin
      hrdata_o = apb_hrdata_i;
      hready_o = apb_hreadyout_i;
      hresp_o  = apb_hresp_i;
    end else if (dp_def_q) begin
      hready_o = ~def_wait_q;
      hresp_o  = ERROR;
    end
  end

endmodule

// File: core_ahb_bridge.sv
`timescale 1ns/1ns

module core_ahb_bridge (
  input  logic                         clk_cpu_i,
  input  logic                         arst_n_i,
  // Core data port
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [soc_pkg::STRB_W-1:0]   be_i,
  input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
  output logic                         gnt_o,
  output logic                         rvalid_o,
  output logic [soc_pkg::DATA_W-1:0]   rdata_o,
  output logic                         err_o,
  // AHB-lite master side
  output soc_pkg::htrans_e             htrans_o,
  output logic [soc_pkg::ADDR_W-1:0]   haddr_o,
  output logic                         hwrite_o,
  output logic [2:0]                   hsize_o,
  output logic [soc_pkg::DATA_W-1:0]   hwdata_o,
  input  logic [soc_pkg::DATA_W-1:0]   hrdata_i,
  input  logic                         hready_i,
  input  soc_pkg::hresp_e              hresp_i
);
  import soc_pkg::*;

  logic              dp_valid_q;
  logic [DATA_W-1:0] wdata_q;
  logic [1:0]        addr_lsb;

  assign gnt_o    = req_i & hready_i;
  assign htrans_o = gnt_o ? NONSEQ : IDLE;
  assign hwrite_o = we_i;
  assign haddr_o  = {addr_i[ADDR_W-1:2], addr_lsb};

  // Contiguous byte enables map to a size, anything else goes out as a word
  always_comb begin
    hsize_o  = 3'b010;
    addr_lsb = 2'b00;
    case (be_i)
      4'b0001: hsize_o = 3'b000;
      4'b0010: begin
        hsize_o  = 3'b000;
        addr_lsb = 2'b01;
      end
      4'b0100: begin
        hsize_o  = 3'b000;
        addr_lsb = 2'b10;
      end
      4'b1000: begin
        hsize_o  = 3'b000;
        addr_lsb = 2'b11;
      end
      4'b0011: hsize_o = 3'b001;
      4'b1100: begin
        hsize_o  = 3'b001;
        addr_lsb = 2'b10;
      end
      default: hsize_o = 3'b010;
    endcase
  end

  // ----------------------------
  // Data phase tracking
  // ----------------------------
  always_ff @(posedge clk_cpu_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dp_valid_q <= 1'b0;
    end else if (hready_i) begin
      dp_valid_q <= req_i;
    end
  end

  always_ff @(posedge clk_cpu_i) begin
    if (gnt_o) begin
      wdata_q <= wdata_i;
    end
  end

  assign hwdata_o = wdata_q;
  assign rvalid_o = dp_valid_q & hready_i;
  assign rdata_o  = hrdata_i;
  assign err_o    = rvalid_o & (hresp_i == ERROR);

endmodule

// File: soc_pkg.sv
package soc_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // ----------------------------
  // Address map
  // ----------------------------
  localparam logic [ADDR_W-1:0] SRAM_BASE   = 32'h0000_0000;
  localparam int                SRAM_AW     = 8;
  localparam logic [ADDR_W-1:0] APB_BASE    = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] REGION_MASK = 32'hF000_0000;

  // PWM register offsets, duty k sits at PWM_DUTY_OFS + 4*k
  localparam logic [7:0] PWM_CTRL_OFS   = 8'h00;
  localparam logic [7:0] PWM_PERIOD_OFS = 8'h04;
  localparam logic [7:0] PWM_DUTY_OFS   = 8'h08;
  localparam int         PWM_CNT_W      = 16;
  localparam int         PWM_CH         = 4;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_e;

  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_e;

endpackage
